// File: Makefile
TB_TOP := tb_sgmii_mux

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f flist.f --top-module $(TB_TOP)

sim:
	verilator --binary --timing -Wno-fatal -f flist.f --top-module $(TB_TOP)
	out=$$(./obj_dir/V$(TB_TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf obj_dir

// File: flist.f
+incdir+src
src/sgmii_mux_pkg.sv
src/port_fifo.sv
src/pkt_counters.sv
src/frame_builder.sv
src/mux_fsm.sv
src/sgmii_mux_top.sv
verification/tb_sgmii_mux.sv

// File: src/frame_builder.sv
`include "sgmii_mux_params.svh"

module frame_builder import sgmii_mux_pkg::*;
(
	input  logic                    clk,
	input  logic                    reset,
	input  build_op_e               op,
	input  logic [`PORT_IDX_W-1:0]  sel,
	input  pkt_word_t               head,
	input  logic [`SLOT_W-1:0]      slot_id,
	input  logic [`CARD_W-1:0]      card_id,
	input  logic [`SEQ_W-1:0]       seq_id,
	input  logic [`LEN_W-1:0]       length,
	output logic                    out_valid,
	output pkt_word_t               out_word,
	output logic                    len_valid,
	output len_word_t               len_word,
	output logic                    rx_pulse
);

	// field positions inside the first metadata word
	localparam int SLOT_LSB   = 110;
	localparam int CARD_LSB   = 74;
	localparam int INPORT_LSB = 58;
	localparam int BUSY_BIT   = 63;

	meta_t      meta;
	pkt_word_t  nxt_word;
	len_word_t  nxt_len;

	always_comb
	begin
		meta.slot_id = slot_id;
		meta.card_id = card_id;
		meta.inport  = 5'(sel);
		meta.seq_id  = seq_id;

		nxt_word = head;
		nxt_len.valid  = 1'b1;
		nxt_len.length = length + `LEN_W'(`WORD_BYTES) - `LEN_W'(head.empty);

		case (op)
			OP_META0:
			begin
				nxt_word      = '0;
				nxt_word.ctrl = CTRL_HEAD;
				nxt_word.data[SLOT_LSB +: `SLOT_W]  = meta.slot_id;
				nxt_word.data[CARD_LSB +: `CARD_W]  = meta.card_id;
				nxt_word.data[INPORT_LSB +: 5]      = meta.inport;
				nxt_word.data[BUSY_BIT]             = 1'b1;
				nxt_word.data[`SEQ_W-1:0]           = meta.seq_id;
			end
			OP_META1:
			begin
				nxt_word      = '0;
				nxt_word.ctrl = CTRL_MID;
			end
			OP_FORWARD:
			begin
				if (head.ctrl == CTRL_HEAD)
					nxt_word.ctrl = CTRL_MID;   // metadata now carries the head
			end
			default:
			begin
				nxt_word = head;   // tail and idle pass the word as is
			end
		endcase
	end

	// ============================================================
	// registered output stage
	// ============================================================
	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			out_valid <= 1'b0;
			len_valid <= 1'b0;
			rx_pulse  <= 1'b0;
		end
		else
		begin
			out_valid <= (op != OP_NONE);
			len_valid <= (op == OP_TAIL);
			rx_pulse  <= (op == OP_TAIL);
		end
	end

	always_ff @(posedge clk)
	begin
		if (op != OP_NONE)
			out_word <= nxt_word;
		if (op == OP_TAIL)
			len_word <= nxt_len;
	end

endmodule

// File: src/mux_fsm.sv
`include "sgmii_mux_params.svh"

module mux_fsm import sgmii_mux_pkg::*;
(
	input  logic                     clk,
	input  logic                     reset,
	input  logic [`SGMII_PORTS-1:0]  stat_empty,
	input  logic [`SGMII_PORTS-1:0]  stat_ok,
	input  ctrl_e                    head_ctrl,      // selected port's head word
	input  logic                     out_almostfull,
	output logic [`PORT_IDX_W-1:0]   sel,
	output logic [`SGMII_PORTS-1:0]  rd,
	output logic [`SGMII_PORTS-1:0]  stat_rd,
	output build_op_e                build_op,
	output logic                     seq_inc,
	output logic                     len_clear,
	output logic                     len_add,
	output logic                     discard_pulse
);

	mux_state_e                state;
	mux_state_e                next_state;
	logic [`PORT_IDX_W-1:0]    port;
	logic [`PORT_IDX_W-1:0]    next_port;
	logic                      discard_done;

	// round-robin successor
	function automatic logic [`PORT_IDX_W-1:0] inc_port(input logic [`PORT_IDX_W-1:0] p);
		if (p == `PORT_IDX_W'(`SGMII_PORTS - 1))
			return '0;
		return p + 1'b1;
	endfunction

	// ============================================================
	// state and served port
	// ============================================================
	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			state         <= ST_SCAN;
			port          <= '0;
			discard_pulse <= 1'b0;
		end
		else
		begin
			state         <= next_state;
			port          <= next_port;
			discard_pulse <= discard_done;
		end
	end

	assign sel = port;

	// ============================================================
	// next state and strobes
	// ============================================================
	always_comb
	begin
		next_state   = state;
		next_port    = port;
		rd           = '0;
		stat_rd      = '0;
		build_op     = OP_NONE;
		seq_inc      = 1'b0;
		len_clear    = 1'b0;
		len_add      = 1'b0;
		discard_done = 1'b0;

		case (state)
			ST_SCAN:
			begin
				// downstream full, hold on this port
				if (!out_almostfull)
				begin
					if (stat_empty[port])
					begin
						next_port = inc_port(port);
					end
					else
					begin
						stat_rd[port] = 1'b1;
						next_state = stat_ok[port] ? ST_META0 : ST_DISCARD;
					end
				end
			end
			ST_DISCARD:
			begin
				rd[port] = 1'b1;   // drop one word per cycle
				if (head_ctrl == CTRL_TAIL)
				begin
					discard_done = 1'b1;
					next_state   = ST_SCAN;
					next_port    = inc_port(port);
				end
			end
			ST_META0:
			begin
				build_op   = OP_META0;
				seq_inc    = 1'b1;
				len_clear  = 1'b1;
				next_state = ST_META1;
			end
			ST_META1:
			begin
				build_op   = OP_META1;
				next_state = ST_XMIT;
			end
			ST_XMIT:
			begin
				rd[port] = 1'b1;
				if (head_ctrl == CTRL_TAIL)
				begin
					build_op   = OP_TAIL;
					next_state = ST_SCAN;
					next_port  = inc_port(port);
				end
				else
				begin
					build_op = OP_FORWARD;
					len_add  = 1'b1;
				end
			end
			default:
			begin
				next_state = ST_SCAN;
			end
		endcase
	end

endmodule

// File: src/pkt_counters.sv
`include "sgmii_mux_params.svh"

module pkt_counters
(
	input  logic                    clk,
	input  logic                    reset,
	input  logic [`PORT_IDX_W-1:0]  sel,
	input  logic                    seq_inc,
	input  logic                    len_clear,
	input  logic                    len_add,
	output logic [`SEQ_W-1:0]       seq_id,
	output logic [`LEN_W-1:0]       length
);

	logic [`SEQ_W-1:0] seq_cnt [`SGMII_PORTS];

	// ============================================================
	// per-port sequence IDs
	// ============================================================
	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			for (int i = 0; i < `SGMII_PORTS; i++)
				seq_cnt[i] <= '0;
		end
		else if (seq_inc)
		begin
			seq_cnt[sel] <= seq_cnt[sel] + 1'b1;
		end
	end

	assign seq_id = seq_cnt[sel];   // value before this packet's increment

	// ============================================================
	// byte count of the packet being sent
	// ============================================================
	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
			length <= '0;
		else if (len_clear)
			length <= `LEN_W'(`META_BYTES);   // metadata words count too
		else if (len_add)
			length <= length + `LEN_W'(`WORD_BYTES);
	end

endmodule

// File: src/port_fifo.sv
`include "sgmii_mux_params.svh"

module port_fifo import sgmii_mux_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  port_in_t   in,
	input  logic       rd,
	input  logic       stat_rd,
	output pkt_word_t  head,
	output logic       stat_ok,
	output logic       stat_empty,
	output logic       almostfull
);

	localparam int PKT_AW  = $clog2(`PKT_FIFO_DEPTH);
	localparam int STAT_AW = $clog2(`STAT_FIFO_DEPTH);

	pkt_word_t            pkt_mem [`PKT_FIFO_DEPTH];
	logic [PKT_AW-1:0]    pkt_wr_ptr;
	logic [PKT_AW-1:0]    pkt_rd_ptr;
	logic [PKT_AW:0]      pkt_cnt;
	logic                 pkt_push;
	logic                 pkt_pop;

	logic                 stat_mem [`STAT_FIFO_DEPTH];
	logic [STAT_AW-1:0]   stat_wr_ptr;
	logic [STAT_AW-1:0]   stat_rd_ptr;
	logic [STAT_AW:0]     stat_cnt;
	logic                 stat_push;
	logic                 stat_pop;

	// overflow and underflow are dropped rather than corrupting pointers
	assign pkt_push  = in.wr && (pkt_cnt != (PKT_AW+1)'(`PKT_FIFO_DEPTH));
	assign pkt_pop   = rd && (pkt_cnt != '0);
	assign stat_push = in.stat_wr && (stat_cnt != (STAT_AW+1)'(`STAT_FIFO_DEPTH));
	assign stat_pop  = stat_rd && !stat_empty;

	// ============================================================
	// packet word FIFO
	// ============================================================
	always_ff @(posedge clk)
	begin
		if (pkt_push)
			pkt_mem[pkt_wr_ptr] <= in.word;
	end

	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			pkt_wr_ptr <= '0;
			pkt_rd_ptr <= '0;
			pkt_cnt    <= '0;
		end
		else
		begin
			if (pkt_push)
				pkt_wr_ptr <= pkt_wr_ptr + 1'b1;
			if (pkt_pop)
				pkt_rd_ptr <= pkt_rd_ptr + 1'b1;
			case ({pkt_push, pkt_pop})
				2'b10:   pkt_cnt <= pkt_cnt + 1'b1;
				2'b01:   pkt_cnt <= pkt_cnt - 1'b1;
				default: pkt_cnt <= pkt_cnt;
			endcase
		end
	end

	assign head       = pkt_mem[pkt_rd_ptr];   // show-ahead
	assign almostfull = pkt_cnt >= (PKT_AW+1)'(`PKT_FIFO_DEPTH / 2);

	// ============================================================
	// status FIFO, one entry per packet
	// ============================================================
	always_ff @(posedge clk)
	begin
		if (stat_push)
			stat_mem[stat_wr_ptr] <= in.stat_ok;
	end

	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			stat_wr_ptr <= '0;
			stat_rd_ptr <= '0;
			stat_cnt    <= '0;
		end
		else
		begin
			if (stat_push)
				stat_wr_ptr <= stat_wr_ptr + 1'b1;
			if (stat_pop)
				stat_rd_ptr <= stat_rd_ptr + 1'b1;
			case ({stat_push, stat_pop})
				2'b10:   stat_cnt <= stat_cnt + 1'b1;
				2'b01:   stat_cnt <= stat_cnt - 1'b1;
				default: stat_cnt <= stat_cnt;
			endcase
		end
	end

	assign stat_ok    = stat_mem[stat_rd_ptr];
	assign stat_empty = (stat_cnt == '0);

endmodule

// File: src/sgmii_mux_params.svh
`ifndef SGMII_MUX_PARAMS_SVH
`define SGMII_MUX_PARAMS_SVH

// ============================================================
// port count and packet word layout
// ============================================================
`define SGMII_PORTS      5
`define PORT_IDX_W       3
`define WORD_W           134
`define DATA_W           128

// ============================================================
// buffering
// ============================================================
`define PKT_FIFO_DEPTH   256     // packet words per port
`define STAT_FIFO_DEPTH  64      // good/bad flags per port

// ============================================================
// metadata and length fields
// ============================================================
`define LEN_W            11
`define SEQ_W            32
`define SLOT_W           3
`define CARD_W           4
`define META_BYTES       32      // two metadata words in front
`define WORD_BYTES       16

// ctrl field of a packet word
`define CTRL_CODE_HEAD   2'b01
`define CTRL_CODE_MID    2'b11
`define CTRL_CODE_TAIL   2'b10

`endif

// File: src/sgmii_mux_pkg.sv
`include "sgmii_mux_params.svh"

package sgmii_mux_pkg;

	// word position within a packet
	typedef enum logic [1:0]
	{
		CTRL_HEAD = `CTRL_CODE_HEAD,
		CTRL_MID  = `CTRL_CODE_MID,
		CTRL_TAIL = `CTRL_CODE_TAIL
	} ctrl_e;

	typedef struct packed
	{
		ctrl_e               ctrl;
		logic [3:0]          empty;  // unused bytes, tail only
		logic [`DATA_W-1:0]  data;
	} pkt_word_t;

	// one receive port, word path plus status path
	typedef struct packed
	{
		logic       wr;
		pkt_word_t  word;
		logic       stat_wr;
		logic       stat_ok;
	} port_in_t;

	typedef struct packed
	{
		logic [`SLOT_W-1:0]  slot_id;
		logic [`CARD_W-1:0]  card_id;
		logic [4:0]          inport;
		logic [`SEQ_W-1:0]   seq_id;
	} meta_t;

	typedef struct packed
	{
		logic               valid;
		logic [`LEN_W-1:0]  length;
	} len_word_t;

	typedef enum logic [2:0]
	{
		ST_SCAN,
		ST_DISCARD,
		ST_META0,
		ST_META1,
		ST_XMIT
	} mux_state_e;

	// what the output stage emits next cycle
	typedef enum logic [2:0]
	{
		OP_NONE,
		OP_META0,
		OP_META1,
		OP_FORWARD,
		OP_TAIL
	} build_op_e;

endpackage

// File: src/sgmii_mux_top.sv
`include "sgmii_mux_params.svh"

module sgmii_mux_top import sgmii_mux_pkg::*;
(
	input  logic                     clk,
	input  logic                     reset,
	input  port_in_t                 port_in [`SGMII_PORTS],
	output logic [`SGMII_PORTS-1:0]  port_almostfull,
	input  logic [`SLOT_W-1:0]       slot_id,
	input  logic [`CARD_W-1:0]       card_id,
	input  logic                     out_almostfull,
	output logic                     out_valid,
	output pkt_word_t                out_word,
	output logic                     len_valid,
	output len_word_t                len_word,
	output logic                     rx_pulse,
	output logic                     discard_pulse
);

	pkt_word_t                 port_head [`SGMII_PORTS];
	logic [`SGMII_PORTS-1:0]   stat_ok;
	logic [`SGMII_PORTS-1:0]   stat_empty;
	logic [`SGMII_PORTS-1:0]   rd;
	logic [`SGMII_PORTS-1:0]   stat_rd;
	logic [`PORT_IDX_W-1:0]    sel;
	pkt_word_t                 sel_head;
	build_op_e                 build_op;
	logic                      seq_inc;
	logic                      len_clear;
	logic                      len_add;
	logic [`SEQ_W-1:0]         seq_id;
	logic [`LEN_W-1:0]         length;

	// ============================================================
	// receive buffers
	// ============================================================
	for (genvar i = 0; i < `SGMII_PORTS; i++)
	begin : g_port
		port_fifo port_fifo_i
		(
			.clk        (clk),
			.reset      (reset),
			.in         (port_in[i]),
			.rd         (rd[i]),
			.stat_rd    (stat_rd[i]),
			.head       (port_head[i]),
			.stat_ok    (stat_ok[i]),
			.stat_empty (stat_empty[i]),
			.almostfull (port_almostfull[i])
		);
	end

	assign sel_head = port_head[sel];   // word of the port being served

	mux_fsm mux_fsm_i
	(
		.clk            (clk),
		.reset          (reset),
		.stat_empty     (stat_empty),
		.stat_ok        (stat_ok),
		.head_ctrl      (sel_head.ctrl),
		.out_almostfull (out_almostfull),
		.sel            (sel),
		.rd             (rd),
		.stat_rd        (stat_rd),
		.build_op       (build_op),
		.seq_inc        (seq_inc),
		.len_clear      (len_clear),
		.len_add        (len_add),
		.discard_pulse  (discard_pulse)
	);

	pkt_counters pkt_counters_i
	(
		.clk       (clk),
		.reset     (reset),
		.sel       (sel),
		.seq_inc   (seq_inc),
		.len_clear (len_clear),
		.len_add   (len_add),
		.seq_id    (seq_id),
		.length    (length)
	);

	frame_builder frame_builder_i
	(
		.clk       (clk),
		.reset     (reset),
		.op        (build_op),
		.sel       (sel),
		.head      (sel_head),
		.slot_id   (slot_id),
		.card_id   (card_id),
		.seq_id    (seq_id),
		.length    (length),
		.out_valid (out_valid),
		.out_word  (out_word),
		.len_valid (len_valid),
		.len_word  (len_word),
		.rx_pulse  (rx_pulse)
	);

endmodule

// File: verification/tb_sgmii_mux.sv
`include "sgmii_mux_params.svh"

module tb_sgmii_mux
	import sgmii_mux_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int WAIT_LIMIT = 2000;   // cycles per wait loop
	localparam int SLOT_LSB   = 110;    // metadata word layout
	localparam int CARD_LSB   = 74;
	localparam int INPORT_LSB = 58;
	localparam int BUSY_BIT   = 63;
	localparam logic [`SLOT_W-1:0] SLOT = 3'd5;
	localparam logic [`CARD_W-1:0] CARD = 4'ha;

	logic clk;
	logic reset;
	port_in_t port_in [`SGMII_PORTS];
	logic [`SGMII_PORTS-1:0] port_almostfull;
	logic out_almostfull;
	logic out_valid;
	pkt_word_t out_word;
	logic len_valid;
	len_word_t len_word;
	logic rx_pulse;
	logic discard_pulse;

	integer seed = 32'h8fa356f7;
	pkt_word_t sent_q [`SGMII_PORTS][$];   // body words of good packets, per port
	logic [`SEQ_W-1:0] exp_seq [`SGMII_PORTS];
	pkt_word_t out_q [$];
	int cyc_q [$];
	len_word_t len_q [$];
	int cycle;
	int rx_count;
	int discard_count;
	int frame_count;
	int word_errs;
	int len_errs;
	int meta_errs;
	int af_errs;
	int other_errs;

	sgmii_mux_top sgmii_mux_top_i
	(
		.clk             (clk),
		.reset           (reset),
		.port_in         (port_in),
		.port_almostfull (port_almostfull),
		.slot_id         (SLOT),
		.card_id         (CARD),
		.out_almostfull  (out_almostfull),
		.out_valid       (out_valid),
		.out_word        (out_word),
		.len_valid       (len_valid),
		.len_word        (len_word),
		.rx_pulse        (rx_pulse),
		.discard_pulse   (discard_pulse)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ============================================================
	// output monitor
	// ============================================================
	always @(posedge clk)
	begin
		cycle++;
		if (out_valid)
		begin
			out_q.push_back(out_word);
			cyc_q.push_back(cycle);
		end
		if (len_valid)
			len_q.push_back(len_word);
		if (rx_pulse)
			rx_count++;
		if (discard_pulse)
			discard_count++;
		// length word belongs to the tail cycle
		if ((len_valid || rx_pulse) &&
			!(len_valid && rx_pulse && out_valid && out_word.ctrl == CTRL_TAIL))
		begin
			other_errs++;
			$display("[ERROR] %0t: length word and rx pulse not aligned with a tail", $time);
		end
	end

	// ============================================================
	// compare tasks
	// ============================================================
	task automatic check_word(input pkt_word_t got, input pkt_word_t exp, input string what);
		if (got !== exp)
		begin
			word_errs++;
			$display("[ERROR] %0t: %s got %b/%0d/%h, expected %b/%0d/%h",
				$time, what, got.ctrl, got.empty, got.data, exp.ctrl, exp.empty, exp.data);
		end
	endtask

	task automatic check_len(input len_word_t got, input len_word_t exp);
		if (got !== exp)
		begin
			len_errs++;
			$display("[ERROR] %0t: length word got %b/%0d, expected %b/%0d",
				$time, got.valid, got.length, exp.valid, exp.length);
		end
	endtask

	task automatic check_meta(input meta_t got, input meta_t exp);
		if (got !== exp)
		begin
			meta_errs++;
			$display("[ERROR] %0t: slot/card/port/seq %0d/%0d/%0d/%0d, expected %0d/%0d/%0d/%0d",
				$time, got.slot_id, got.card_id, got.inport, got.seq_id,
				exp.slot_id, exp.card_id, exp.inport, exp.seq_id);
		end
	endtask

	task automatic check_almostfull(input logic [`SGMII_PORTS-1:0] got,
		input logic [`SGMII_PORTS-1:0] exp, input string what);
		if (got !== exp)
		begin
			af_errs++;
			$display("[ERROR] %0t: port almost-full %s got %b, expected %b",
				$time, what, got, exp);
		end
	endtask

	function automatic meta_t meta_fields(input pkt_word_t w);
		meta_t m;
		m.slot_id = w.data[SLOT_LSB +: `SLOT_W];
		m.card_id = w.data[CARD_LSB +: `CARD_W];
		m.inport  = w.data[INPORT_LSB +: 5];
		m.seq_id  = w.data[`SEQ_W-1:0];
		return m;
	endfunction

	function automatic pkt_word_t meta_word(input meta_t m);
		pkt_word_t w;
		w = '0;
		w.ctrl = CTRL_HEAD;
		w.data[SLOT_LSB +: `SLOT_W] = m.slot_id;
		w.data[CARD_LSB +: `CARD_W] = m.card_id;
		w.data[INPORT_LSB +: 5]     = m.inport;
		w.data[BUSY_BIT]            = 1'b1;   // busy flag
		w.data[`SEQ_W-1:0]          = m.seq_id;
		return w;
	endfunction

	task automatic print_counts();
		$display("errors: word %0d, length %0d, meta %0d, almost-full %0d, other %0d",
			word_errs, len_errs, meta_errs, af_errs, other_errs);
	endtask

	task automatic end_on_failure(input string msg);
		$display("run aborted: %s", msg);
		print_counts();
		$display("STATUS: FAIL");
		$finish;
	endtask

	// ============================================================
	// drivers and waits
	// ============================================================
	task automatic send_packet(input int port, input int nwords, input logic [3:0] empty,
		input bit ok);
		pkt_word_t w;
		int t;
		for (int i = 0; i < nwords; i++)
		begin
			t = 0;
			while (port_almostfull[port])
			begin
				@(posedge clk);
				#1;
				t++;
				if (t > WAIT_LIMIT)
					end_on_failure("port almost-full never went low");
			end
			w.ctrl  = (i == 0) ? CTRL_HEAD : ((i == nwords - 1) ? CTRL_TAIL : CTRL_MID);
			w.empty = (i == nwords - 1) ? empty : 4'd0;
			w.data  = {$random(seed), $random(seed), $random(seed), $random(seed)};
			port_in[port].wr      = 1'b1;
			port_in[port].word    = w;
			port_in[port].stat_wr = (i == nwords - 1);   // status goes with the tail
			port_in[port].stat_ok = ok;
			if (ok)
				sent_q[port].push_back(w);
			@(posedge clk);
			#1;
		end
		port_in[port] = '0;
	endtask

	task automatic wait_words(input int n);
		int t;
		t = 0;
		while (out_q.size() < n)
		begin
			@(posedge clk);
			#1;
			t++;
			if (t > WAIT_LIMIT)
				end_on_failure("no output word arrived in time");
		end
	endtask

	task automatic next_word(inout int last_cyc, output pkt_word_t w);
		int c;
		wait_words(1);
		w = out_q.pop_front();
		c = cyc_q.pop_front();
		if (c != last_cyc + 1)
		begin
			other_errs++;
			$display("[ERROR] %0t: gap of %0d cycles inside a frame", $time, c - last_cyc - 1);
		end
		last_cyc = c;
	endtask

	// one frame: metadata, body and length, checked against what its port sent
	task automatic collect_frame(output int port);
		pkt_word_t w;
		pkt_word_t exp_w;
		meta_t got_m;
		meta_t exp_m;
		logic [`LEN_W-1:0] exp_len;
		int last_cyc;
		bit done;
		int t;
		wait_words(1);
		w = out_q.pop_front();
		last_cyc = cyc_q.pop_front();
		got_m = meta_fields(w);
		port = int'(got_m.inport);
		if (port >= `SGMII_PORTS || sent_q[port].size() == 0)
			end_on_failure("frame came from a port with nothing queued");
		exp_m = '{slot_id: SLOT, card_id: CARD, inport: 5'(port), seq_id: exp_seq[port]};
		check_meta(got_m, exp_m);
		check_word(w, meta_word(exp_m), "meta0");
		exp_seq[port]++;
		next_word(last_cyc, w);
		check_word(w, '{ctrl: CTRL_MID, empty: 4'd0, data: '0}, "meta1");
		exp_len = `LEN_W'(`META_BYTES);
		done = 1'b0;
		while (!done)
		begin
			if (sent_q[port].size() == 0)
				end_on_failure("frame ran past the tail that was sent");
			exp_w = sent_q[port].pop_front();
			done = (exp_w.ctrl == CTRL_TAIL);
			if (exp_w.ctrl == CTRL_HEAD)
				exp_w.ctrl = CTRL_MID;   // head recoded behind the metadata
			next_word(last_cyc, w);
			check_word(w, exp_w, "body");
			exp_len = exp_len + `LEN_W'(`WORD_BYTES);
			if (done)
				exp_len = exp_len - `LEN_W'(exp_w.empty);
		end
		t = 0;
		while (len_q.size() == 0)
		begin
			@(posedge clk);
			#1;
			t++;
			if (t > WAIT_LIMIT)
				end_on_failure("length word missing after a tail");
		end
		check_len(len_q.pop_front(), '{valid: 1'b1, length: exp_len});
		frame_count++;
	endtask

	task automatic expect_port(input int got, input int exp);
		if (got != exp)
		begin
			other_errs++;
			$display("[ERROR] %0t: frame came from port %0d, expected port %0d", $time, got, exp);
		end
	endtask

	// ============================================================
	// tests
	// ============================================================
	task automatic test_good_packet();
		int port;
		int rx_before;
		rx_before = rx_count;
		send_packet(0, 4, 4'd5, 1'b1);   // length 32 + 64 - 5 = 91
		collect_frame(port);
		expect_port(port, 0);
		if (rx_count != rx_before + 1)
		begin
			other_errs++;
			$display("[ERROR] %0t: rx pulse seen %0d times", $time, rx_count - rx_before);
		end
	endtask

	task automatic test_bad_packet();
		int port;
		int t;
		int disc_before;
		disc_before = discard_count;
		send_packet(3, 5, 4'd2, 1'b0);
		t = 0;
		while (discard_count == disc_before)
		begin
			@(posedge clk);
			#1;
			t++;
			if (t > WAIT_LIMIT)
				end_on_failure("bad packet was never discarded");
		end
		repeat (10) @(posedge clk);
		#1;
		if (out_q.size() != 0 || len_q.size() != 0 || discard_count != disc_before + 1)
		begin
			other_errs++;
			$display("[ERROR] %0t: discard left %0d words, %0d lengths, %0d pulses",
				$time, out_q.size(), len_q.size(), discard_count - disc_before);
		end
		send_packet(3, 3, 4'd0, 1'b1);
		collect_frame(port);   // seq still 0 after the drop
		expect_port(port, 3);
	endtask

	task automatic test_seq_ids();
		int port;
		int per_port [`SGMII_PORTS];
		per_port = '{default: 0};
		send_packet(1, 3, 4'd1, 1'b1);
		send_packet(1, 5, 4'd15, 1'b1);
		send_packet(4, 4, 4'd7, 1'b1);
		send_packet(1, 2, 4'd0, 1'b1);
		repeat (4)
		begin
			collect_frame(port);
			per_port[port]++;
		end
		if (per_port[1] != 3 || per_port[4] != 1)
		begin
			other_errs++;
			$display("[ERROR] %0t: frames from port 1: %0d, port 4: %0d", $time,
				per_port[1], per_port[4]);
		end
	endtask

	task automatic test_all_ports();
		int port;
		int per_port [`SGMII_PORTS];
		per_port = '{default: 0};
		out_almostfull = 1'b1;   // keep everything queued until all are in
		for (int p = 0; p < `SGMII_PORTS; p++)
			send_packet(p, p + 2, 4'(p * 3), 1'b1);
		out_almostfull = 1'b0;
		for (int i = 0; i < `SGMII_PORTS; i++)
		begin
			collect_frame(port);
			per_port[port]++;
		end
		for (int p = 0; p < `SGMII_PORTS; p++)
		begin
			if (per_port[p] != 1)
			begin
				other_errs++;
				$display("[ERROR] %0t: port %0d sent %0d frames", $time, p, per_port[p]);
			end
		end
	endtask

	task automatic test_backpressure();
		int port;
		out_almostfull = 1'b1;
		send_packet(2, 4, 4'd9, 1'b1);
		repeat (50) @(posedge clk);
		#1;
		if (out_q.size() != 0)
		begin
			other_errs++;
			$display("[ERROR] %0t: %0d words left while downstream was full", $time, out_q.size());
		end
		out_almostfull = 1'b0;
		collect_frame(port);
		expect_port(port, 2);
	endtask

	// port 2 filled to half its packet FIFO while the output is held
	task automatic test_port_almostfull();
		int port;
		logic [`SGMII_PORTS-1:0] exp_af;
		exp_af = '0;
		out_almostfull = 1'b1;
		send_packet(2, 100, 4'd3, 1'b1);
		check_almostfull(port_almostfull, exp_af, "below half depth");
		send_packet(2, 28, 4'd4, 1'b1);   // 128 words queued
		exp_af[2] = 1'b1;
		check_almostfull(port_almostfull, exp_af, "at half depth");
		out_almostfull = 1'b0;
		collect_frame(port);
		expect_port(port, 2);
		collect_frame(port);
		expect_port(port, 2);
		check_almostfull(port_almostfull, '0, "after draining");
	endtask

	initial
	begin
		reset = 1'b0;
		out_almostfull = 1'b0;
		cycle = 0;
		rx_count = 0;
		discard_count = 0;
		frame_count = 0;
		word_errs = 0;
		len_errs = 0;
		meta_errs = 0;
		af_errs = 0;
		other_errs = 0;
		for (int p = 0; p < `SGMII_PORTS; p++)
		begin
			port_in[p] = '0;
			exp_seq[p] = '0;
		end
		repeat (16) @(posedge clk);
		#1;
		reset = 1'b1;
		if (out_valid || len_valid || rx_pulse || discard_pulse)
		begin
			other_errs++;
			$display("[ERROR] %0t: outputs active right after reset", $time);
		end

		test_good_packet();
		test_bad_packet();
		test_seq_ids();
		test_all_ports();
		test_backpressure();
		test_port_almostfull();

		repeat (20) @(posedge clk);
		#1;
		if (out_q.size() != 0 || len_q.size() != 0 || rx_count != frame_count)
		begin
			other_errs++;
			$display("[ERROR] %0t: stray words %0d, lengths %0d, rx pulses %0d for %0d frames",
				$time, out_q.size(), len_q.size(), rx_count, frame_count);
		end

		print_counts();
		if (word_errs + len_errs + meta_errs + af_errs + other_errs == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule
